// ==== design/dtlb_entry.sv ====
/*
 * One fully associative data TLB entry with fill, flush
 * and tag compare
 */
`timescale 1ns/100ps

module dtlb_entry (
   input  logic                     clk_i,
   input  logic                     reset_i,
   input  logic                     flush_i,
   input  logic                     fill_v_i,
   input  mem_addr_pkg::tlb_fill_s  fill_i,
   input  mem_addr_pkg::vtag_t      lookup_vtag_i,
   output logic                     hit_o,
   output mem_addr_pkg::tlb_entry_s entry_o
);

   logic                     valid_r;
   mem_addr_pkg::vtag_t      vtag_r;
   mem_addr_pkg::tlb_entry_s entry_r;

   // A fill in the same cycle as a flush keeps the entry
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         valid_r <= 1'b0;
      end else if (fill_v_i) begin
         valid_r <= 1'b1;
      end else if (flush_i) begin
         valid_r <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (fill_v_i) begin
         vtag_r  <= fill_i.vtag;
         entry_r <= fill_i.entry;
      end
   end

   // Compare against state before the edge
   assign hit_o   = valid_r & (vtag_r == lookup_vtag_i);
   assign entry_o = entry_r;

endmodule

// ==== design/mem_addr_pkg.sv ====
/*
 * Address widths for the data memory pipe, virtual and physical
 * tag typedefs, TLB entry and TLB fill structs
 */
package mem_addr_pkg;

   localparam int vaddr_width_gp       = 39;
   localparam int page_offset_width_gp = 12;
   localparam int ptag_width_gp        = 16;

   // Derived widths
   localparam int vtag_width_gp  = vaddr_width_gp - page_offset_width_gp;
   localparam int paddr_width_gp = ptag_width_gp + page_offset_width_gp;

   typedef logic [vaddr_width_gp-1:0]       vaddr_t;
   typedef logic [vtag_width_gp-1:0]        vtag_t;
   typedef logic [ptag_width_gp-1:0]        ptag_t;
   typedef logic [page_offset_width_gp-1:0] page_offset_t;
   typedef logic [paddr_width_gp-1:0]       paddr_t;

   // Leaf PTE bits kept per TLB entry
   typedef struct packed {
      ptag_t ptag;
      logic  u;
      logic  w;
      logic  d;
   } tlb_entry_s;

   // Fill from outside, the walker itself is not part of the pipe
   typedef struct packed {
      vtag_t      vtag;
      tlb_entry_s entry;
   } tlb_fill_s;

endpackage

// ==== design/mem_dmem.sv ====
/*
 * Physical dword memory with byte-lane stores and
 * sign or zero extended registered loads
 */
`timescale 1ns/100ps

module mem_dmem #(
   parameter int dmem_words_p = 64
) (
   input  logic                  clk_i,
   input  logic                  acc_v_i,
   input  mem_addr_pkg::paddr_t  acc_paddr_i,
   input  mem_op_pkg::mem_op_e   acc_op_i,
   input  mem_op_pkg::reg_data_t acc_data_i,
   output mem_op_pkg::reg_data_t load_data_o
);

   localparam int idx_width_lp = (dmem_words_p > 1) ? $clog2(dmem_words_p) : 1;

   mem_op_pkg::reg_data_t   mem_r [dmem_words_p];
   mem_op_pkg::reg_data_t   wdata, rdata, load_ext, load_data_r;
   logic [idx_width_lp-1:0] idx;
   logic [2:0]              off;
   logic [1:0]              size;
   logic [7:0]              lane_mask, byte_en;
   logic                    is_store;

   assign idx      = acc_paddr_i[3 +: idx_width_lp];
   assign off      = acc_paddr_i[2:0];
   assign size     = mem_op_pkg::op_size_log2(acc_op_i);
   assign is_store = mem_op_pkg::op_is_store(acc_op_i);

   always_comb begin
      case (size)
         2'd0:    lane_mask = 8'h01;
         2'd1:    lane_mask = 8'h03;
         2'd2:    lane_mask = 8'h0f;
         default: lane_mask = 8'hff;
      endcase
   end

   // Address is aligned here, so the lanes never wrap
   assign byte_en = lane_mask << off;
   assign wdata   = acc_data_i << {off, 3'b000};
   assign rdata   = mem_r[idx] >> {off, 3'b000};

   always_comb begin
      case (acc_op_i)
         mem_op_pkg::e_lb:  load_ext = {{56{rdata[7]}}, rdata[7:0]};
         mem_op_pkg::e_lbu: load_ext = {56'b0, rdata[7:0]};
         mem_op_pkg::e_lh:  load_ext = {{48{rdata[15]}}, rdata[15:0]};
         mem_op_pkg::e_lhu: load_ext = {48'b0, rdata[15:0]};
         mem_op_pkg::e_lw:  load_ext = {{32{rdata[31]}}, rdata[31:0]};
         mem_op_pkg::e_lwu: load_ext = {32'b0, rdata[31:0]};
         mem_op_pkg::e_ld:  load_ext = rdata;
         default:           load_ext = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (acc_v_i && is_store) begin
         for (int b = 0; b < 8; b++) begin
            if (byte_en[b]) begin
               mem_r[idx][b*8 +: 8] <= wdata[b*8 +: 8];
            end
         end
      end
      // Stores and blocked accesses return zero
      load_data_r <= (acc_v_i && !is_store) ? load_ext : '0;
   end

   assign load_data_o = load_data_r;

endmodule

// ==== design/mem_issue.sv ====
/*
 * Issue stage: effective address, canonical check, stage-1
 * register and round-robin TLB fill steering
 */
`timescale 1ns/100ps

module mem_issue #(
   parameter int dtlb_els_p = 4
) (
   input  logic                          clk_i,
   input  logic                          reset_i,
   input  logic                          req_v_i,
   input  mem_op_pkg::mem_req_s          req_i,
   input  logic                          fill_v_i,
   output mem_op_pkg::mem_stage_s        stage_o,
   output mem_addr_pkg::vtag_t           lookup_vtag_o,
   output logic [dtlb_els_p-1:0]         fill_sel_o
);

   localparam int eaddr_pad_lp = 64 - mem_addr_pkg::vaddr_width_gp;
   localparam int ptr_width_lp = (dtlb_els_p > 1) ? $clog2(dtlb_els_p) : 1;
   localparam logic [dtlb_els_p-1:0] sel_one_lp = 1;

   mem_op_pkg::reg_data_t   eaddr;
   logic                    eaddr_fault;
   mem_op_pkg::mem_stage_s  stage_r;
   logic [ptr_width_lp-1:0] fill_ptr_r;

   assign eaddr = req_i.rs1 + req_i.imm;

   // Upper bits must replicate the top vaddr bit
   assign eaddr_fault = eaddr[63:mem_addr_pkg::vaddr_width_gp]
                        != {eaddr_pad_lp{eaddr[mem_addr_pkg::vaddr_width_gp-1]}};

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         stage_r.valid <= 1'b0;
      end else begin
         stage_r.valid <= req_v_i;
      end
      if (req_v_i) begin
         stage_r.op          <= req_i.op;
         stage_r.eaddr_fault <= eaddr_fault;
         stage_r.vaddr       <= eaddr[mem_addr_pkg::vaddr_width_gp-1:0];
         stage_r.data        <= req_i.rs2;
      end
   end

   assign stage_o = stage_r;

   // TLB lookup happens in the checker cycle
   assign lookup_vtag_o =
      stage_r.vaddr[mem_addr_pkg::page_offset_width_gp +: mem_addr_pkg::vtag_width_gp];

   // Replacement pointer steps once per fill
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         fill_ptr_r <= '0;
      end else if (fill_v_i) begin
         if (fill_ptr_r == ptr_width_lp'(dtlb_els_p - 1)) begin
            fill_ptr_r <= '0;
         end else begin
            fill_ptr_r <= fill_ptr_r + 1'b1;
         end
      end
   end

   assign fill_sel_o = fill_v_i ? (sel_one_lp << fill_ptr_r) : '0;

   a_fill_sel_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
      $onehot0(fill_sel_o))
      else $error("fill_sel_o selects more than one TLB entry");

endmodule

// ==== design/mem_op_pkg.sv ====
/*
 * Memory op and fault encodings, register data type, request,
 * translation info, stage and result structs, op decode functions
 */
package mem_op_pkg;

   typedef enum logic [3:0] {
      e_lb, e_lbu, e_lh, e_lhu, e_lw, e_lwu, e_ld,
      e_sb, e_sh, e_sw, e_sd
   } mem_op_e;

   typedef enum logic [2:0] {
      e_fault_none,
      e_fault_misaligned,
      e_fault_page,
      e_fault_access,
      e_fault_tlb_miss
   } mem_fault_e;

   typedef logic [63:0] reg_data_t;

   typedef struct packed {
      mem_op_e   op;
      reg_data_t rs1;
      reg_data_t rs2;
      reg_data_t imm;
   } mem_req_s;

   // priv_user is 1 for U mode, 0 for S mode
   typedef struct packed {
      logic translation_en;
      logic priv_user;
      logic mstatus_sum;
   } trans_info_s;

   typedef struct packed {
      logic                 valid;
      mem_op_e              op;
      logic                 eaddr_fault;
      mem_addr_pkg::vaddr_t vaddr;
      reg_data_t            data;
   } mem_stage_s;

   typedef struct packed {
      mem_fault_e           fault;
      mem_addr_pkg::vaddr_t vaddr;
      reg_data_t            data;
   } mem_result_s;

   function automatic logic op_is_store(mem_op_e op);
      return op inside {e_sb, e_sh, e_sw, e_sd};
   endfunction

   // Access size as log2 of the byte count
   function automatic logic [1:0] op_size_log2(mem_op_e op);
      case (op)
         e_lb, e_lbu, e_sb: return 2'd0;
         e_lh, e_lhu, e_sh: return 2'd1;
         e_lw, e_lwu, e_sw: return 2'd2;
         default:           return 2'd3;
      endcase
   endfunction

endpackage

// ==== design/mem_pipe.sv ====
/*
 * Top of the data memory pipe: issue, TLB entries,
 * translate and check stage, physical memory
 */
`timescale 1ns/100ps

module mem_pipe #(
   parameter int dtlb_els_p   = 4,
   parameter int dmem_words_p = 64
) (
   input  logic                    clk_i,
   input  logic                    reset_i,
   input  logic                    req_v_i,
   input  mem_op_pkg::mem_req_s    req_i,
   input  mem_op_pkg::trans_info_s trans_i,
   input  logic                    fill_v_i,
   input  mem_addr_pkg::tlb_fill_s fill_i,
   input  logic                    sfence_i,
   output logic                    result_v_o,
   output mem_op_pkg::mem_result_s result_o
);

   mem_op_pkg::mem_stage_s                    stage;
   mem_addr_pkg::vtag_t                       lookup_vtag;
   logic [dtlb_els_p-1:0]                     fill_sel;
   logic [dtlb_els_p-1:0]                     tlb_hit;
   mem_addr_pkg::tlb_entry_s [dtlb_els_p-1:0] tlb_entries;
   logic                                      acc_v;
   mem_addr_pkg::paddr_t                      acc_paddr;
   mem_op_pkg::mem_op_e                       acc_op;
   mem_op_pkg::reg_data_t                     acc_data;
   mem_op_pkg::reg_data_t                     load_data;
   mem_op_pkg::mem_fault_e                    fault;
   mem_addr_pkg::vaddr_t                      vaddr;

   mem_issue #(.dtlb_els_p(dtlb_els_p)) issue0 (
      .clk_i(clk_i), .reset_i(reset_i),
      .req_v_i(req_v_i), .req_i(req_i), .fill_v_i(fill_v_i),
      .stage_o(stage), .lookup_vtag_o(lookup_vtag), .fill_sel_o(fill_sel)
   );

   for (genvar i = 0; i < dtlb_els_p; i++) begin : g_dtlb
      dtlb_entry entry0 (
         .clk_i(clk_i), .reset_i(reset_i), .flush_i(sfence_i),
         .fill_v_i(fill_sel[i]), .fill_i(fill_i),
         .lookup_vtag_i(lookup_vtag),
         .hit_o(tlb_hit[i]), .entry_o(tlb_entries[i])
      );
   end

   mem_xlate_check #(.dtlb_els_p(dtlb_els_p), .dmem_words_p(dmem_words_p)) xlate0 (
      .clk_i(clk_i), .reset_i(reset_i),
      .stage_i(stage), .trans_i(trans_i),
      .hit_i(tlb_hit), .entries_i(tlb_entries),
      .acc_v_o(acc_v), .acc_paddr_o(acc_paddr), .acc_op_o(acc_op), .acc_data_o(acc_data),
      .result_v_o(result_v_o), .fault_o(fault), .vaddr_o(vaddr)
   );

   mem_dmem #(.dmem_words_p(dmem_words_p)) dmem0 (
      .clk_i(clk_i), .acc_v_i(acc_v), .acc_paddr_i(acc_paddr),
      .acc_op_i(acc_op), .acc_data_i(acc_data), .load_data_o(load_data)
   );

   assign result_o = '{fault: fault, vaddr: vaddr, data: load_data};

endmodule

// ==== design/mem_xlate_check.sv ====
/*
 * Translate and check stage: TLB hit select or passthrough,
 * prioritized fault checks, memory access gating, stage-2 status
 */
`timescale 1ns/100ps

module mem_xlate_check #(
   parameter int dtlb_els_p   = 4,
   parameter int dmem_words_p = 64
) (
   input  logic                                     clk_i,
   input  logic                                     reset_i,
   input  mem_op_pkg::mem_stage_s                   stage_i,
   input  mem_op_pkg::trans_info_s                  trans_i,
   input  logic [dtlb_els_p-1:0]                    hit_i,
   input  mem_addr_pkg::tlb_entry_s [dtlb_els_p-1:0] entries_i,
   output logic                                     acc_v_o,
   output mem_addr_pkg::paddr_t                     acc_paddr_o,
   output mem_op_pkg::mem_op_e                      acc_op_o,
   output mem_op_pkg::reg_data_t                    acc_data_o,
   output logic                                     result_v_o,
   output mem_op_pkg::mem_fault_e                   fault_o,
   output mem_addr_pkg::vaddr_t                     vaddr_o
);

   localparam int unsigned dmem_bytes_lp = dmem_words_p * 8;
   localparam int offset_w_lp = mem_addr_pkg::page_offset_width_gp;

   mem_addr_pkg::tlb_entry_s entry_sel;
   mem_addr_pkg::ptag_t      ptag;
   mem_addr_pkg::paddr_t     paddr;
   mem_op_pkg::mem_fault_e   fault;
   mem_op_pkg::mem_fault_e   fault_r;
   mem_addr_pkg::vaddr_t     vaddr_r;
   logic                     result_v_r;
   logic [1:0]               size;
   logic                     hit_any, is_store, xlate_on;
   logic                     misaligned, priv_fault, write_fault;
   logic                     page_fault, tlb_miss, access_fault;

   always_comb begin
      entry_sel = '0;
      for (int i = 0; i < dtlb_els_p; i++) begin
         if (hit_i[i]) begin
            entry_sel = entries_i[i];
         end
      end
   end

   assign hit_any  = |hit_i;
   assign xlate_on = trans_i.translation_en;
   assign is_store = mem_op_pkg::op_is_store(stage_i.op);
   assign size     = mem_op_pkg::op_size_log2(stage_i.op);

   // Passthrough takes the physical tag straight from the vaddr
   assign ptag  = xlate_on ? entry_sel.ptag
                           : stage_i.vaddr[offset_w_lp +: mem_addr_pkg::ptag_width_gp];
   assign paddr = {ptag, stage_i.vaddr[offset_w_lp-1:0]};

   always_comb begin
      case (size)
         2'd0:    misaligned = 1'b0;
         2'd1:    misaligned = stage_i.vaddr[0];
         2'd2:    misaligned = |stage_i.vaddr[1:0];
         default: misaligned = |stage_i.vaddr[2:0];
      endcase
   end

   assign priv_fault  = trans_i.priv_user ? ~entry_sel.u
                                          : (entry_sel.u & ~trans_i.mstatus_sum);
   assign write_fault = is_store & ~(entry_sel.w & entry_sel.d);
   assign page_fault  = xlate_on & (stage_i.eaddr_fault
                                    | (hit_any & (priv_fault | write_fault)));
   assign tlb_miss     = xlate_on & ~hit_any;
   assign access_fault = 32'(paddr) >= dmem_bytes_lp;

   assign fault = misaligned   ? mem_op_pkg::e_fault_misaligned :
                  page_fault   ? mem_op_pkg::e_fault_page       :
                  tlb_miss     ? mem_op_pkg::e_fault_tlb_miss   :
                  access_fault ? mem_op_pkg::e_fault_access     :
                                 mem_op_pkg::e_fault_none;

   // Only clean accesses reach the memory
   assign acc_v_o     = stage_i.valid & (fault == mem_op_pkg::e_fault_none);
   assign acc_paddr_o = paddr;
   assign acc_op_o    = stage_i.op;
   assign acc_data_o  = stage_i.data;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         result_v_r <= 1'b0;
      end else begin
         result_v_r <= stage_i.valid;
      end
      if (stage_i.valid) begin
         fault_r <= fault;
         vaddr_r <= stage_i.vaddr;
      end
   end

   assign result_v_o = result_v_r;
   assign fault_o    = fault_r;
   assign vaddr_o    = vaddr_r;

   a_single_hit: assert property (@(posedge clk_i) disable iff (reset_i)
      stage_i.valid && xlate_on |-> $onehot0(hit_i))
      else $error("more than one TLB entry hit on a lookup");

endmodule

// ==== mem_pipe.f ====
design/mem_addr_pkg.sv
design/mem_op_pkg.sv
design/mem_issue.sv
design/dtlb_entry.sv
design/mem_xlate_check.sv
design/mem_dmem.sv
design/mem_pipe.sv
tests/mem_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the mem_pipe testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module mem_pipe_tb -f mem_pipe.f \
   && ./obj_dir/Vmem_pipe_tb | tee /dev/stderr | grep -x "Verification passed" > /dev/null \
   && echo "Simulation run OK" \
   || { echo "Simulation run FAILED"; exit 1; }

// ==== tests/mem_pipe_tb.sv ====
/*
 * Testbench for mem_pipe: clock, reset, LCG stimulus,
 * reference byte memory, TLB model and result checks
 */
`timescale 1ns/100ps

module mem_pipe_tb;

   localparam int tlb_els_lp      = 4;
   localparam int dmem_words_lp   = 64;
   localparam int dmem_bytes_lp   = dmem_words_lp * 8;
   localparam int reset_cycles_lp = 16;
   localparam int rand_off_lp     = 200;
   // Per privilege mode, three modes
   localparam int rand_on_lp      = 60;
   localparam int directed_lp     = 120;
   localparam int timeout_cycles_lp = 4 * (reset_cycles_lp + dmem_words_lp + rand_off_lp
                                           + 3 * rand_on_lp + directed_lp);

   logic                    clk_i = 1'b0;
   logic                    reset_i;
   logic                    req_v_i;
   mem_op_pkg::mem_req_s    req_i;
   mem_op_pkg::trans_info_s trans_i;
   logic                    fill_v_i;
   mem_addr_pkg::tlb_fill_s fill_i;
   logic                    sfence_i;
   logic                    result_v_o;
   mem_op_pkg::mem_result_s result_o;

   // Reference state
   logic [7:0]               ref_mem [dmem_bytes_lp];
   logic                     m_valid [tlb_els_lp];
   mem_addr_pkg::vtag_t      m_vtag  [tlb_els_lp];
   mem_addr_pkg::tlb_entry_s m_entry [tlb_els_lp];
   int                       m_ptr;
   mem_op_pkg::mem_result_s  exp_q [$];
   mem_op_pkg::mem_result_s  exp_r;
   int                       results_seen = 0;
   int                       cycle_count = 0;
   logic [1:0]               req_hist;
   logic [31:0]              lcg_state;

   mem_pipe #(.dtlb_els_p(tlb_els_lp), .dmem_words_p(dmem_words_lp)) dut0 (
      .clk_i(clk_i), .reset_i(reset_i), .req_v_i(req_v_i), .req_i(req_i),
      .trans_i(trans_i), .fill_v_i(fill_v_i), .fill_i(fill_i), .sfence_i(sfence_i),
      .result_v_o(result_v_o), .result_o(result_o)
   );

   always #4 clk_i = ~clk_i;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // Upper bits only, the low LCG bits cycle quickly
   function automatic int rnd(input int n);
      return int'((lcg_next() >> 8) % 32'(n));
   endfunction

   function automatic logic [63:0] rand64();
      return {lcg_next(), lcg_next()};
   endfunction

   function automatic int op_bytes(input mem_op_pkg::mem_op_e op);
      case (op)
         mem_op_pkg::e_lb, mem_op_pkg::e_lbu, mem_op_pkg::e_sb: return 1;
         mem_op_pkg::e_lh, mem_op_pkg::e_lhu, mem_op_pkg::e_sh: return 2;
         mem_op_pkg::e_lw, mem_op_pkg::e_lwu, mem_op_pkg::e_sw: return 4;
         default: return 8;
      endcase
   endfunction

   function automatic logic [63:0] page_addr(input mem_addr_pkg::vtag_t vt,
                                             input logic [11:0] off);
      return {25'b0, vt, off};
   endfunction

   task automatic report_mismatch(input string name, input logic [63:0] expv,
                                  input logic [63:0] actv);
      $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expv, actv);
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic report_failure(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      $display("Verification failed");
      $fatal(1);
   endtask

   // Expected result from the fault priority and the reference state
   task automatic predict(input mem_op_pkg::mem_op_e op, input logic [63:0] eaddr,
                          input logic [63:0] wdata);
      mem_addr_pkg::vaddr_t     va;
      mem_addr_pkg::tlb_entry_s ent;
      mem_op_pkg::mem_fault_e   fault;
      logic [27:0]              pa;
      logic [63:0]              data;
      logic                     noncanon, hit, store, priv_bad, xlate;
      int                       nb;
      va = eaddr[38:0];
      noncanon = eaddr[63:39] != {25{eaddr[38]}};
      nb = op_bytes(op);
      store = op inside {mem_op_pkg::e_sb, mem_op_pkg::e_sh, mem_op_pkg::e_sw,
                         mem_op_pkg::e_sd};
      xlate = trans_i.translation_en;
      hit = 1'b0;
      ent = '0;
      for (int k = 0; k < tlb_els_lp; k++) begin
         if (m_valid[k] && m_vtag[k] == va[38:12]) begin
            hit = 1'b1;
            ent = m_entry[k];
         end
      end
      pa = xlate ? {ent.ptag, va[11:0]} : va[27:0];
      priv_bad = trans_i.priv_user ? !ent.u : (ent.u && !trans_i.mstatus_sum);
      if ((va[2:0] & 3'(nb - 1)) != 3'b0) begin
         fault = mem_op_pkg::e_fault_misaligned;
      end else if (xlate && (noncanon || (hit && (priv_bad || (store && !(ent.w && ent.d))))))
      begin
         fault = mem_op_pkg::e_fault_page;
      end else if (xlate && !hit) begin
         fault = mem_op_pkg::e_fault_tlb_miss;
      end else if (pa >= 28'(dmem_bytes_lp)) begin
         fault = mem_op_pkg::e_fault_access;
      end else begin
         fault = mem_op_pkg::e_fault_none;
      end
      data = '0;
      if (fault == mem_op_pkg::e_fault_none) begin
         for (int k = 0; k < nb; k++) begin
            if (store) begin
               ref_mem[int'(pa) + k] = wdata[8*k +: 8];
            end else begin
               data[8*k +: 8] = ref_mem[int'(pa) + k];
            end
         end
         if (op inside {mem_op_pkg::e_lb, mem_op_pkg::e_lh, mem_op_pkg::e_lw}
             && data[8*nb-1]) begin
            for (int k = 8 * nb; k < 64; k++) begin
               data[k] = 1'b1;
            end
         end
      end
      exp_q.push_back('{fault: fault, vaddr: va, data: data});
   endtask

   task automatic send(input mem_op_pkg::mem_op_e op, input logic [63:0] eaddr,
                       input logic [63:0] wdata);
      logic [63:0] rs1;
      rs1 = rand64();
      predict(op, eaddr, wdata);
      req_i = '{op: op, rs1: rs1, rs2: wdata, imm: eaddr - rs1};
      req_v_i = 1'b1;
      @(posedge clk_i);
      #1;
      req_v_i = 1'b0;
   endtask

   task automatic rand_access(input mem_addr_pkg::vtag_t vt);
      mem_op_pkg::mem_op_e op;
      int                  nb;
      logic [11:0]         off;
      op = mem_op_pkg::mem_op_e'(4'(rnd(11)));
      nb = op_bytes(op);
      off = 12'(rnd(dmem_bytes_lp) & ~(nb - 1));
      send(op, page_addr(vt, off), rand64());
   endtask

   task automatic drain();
      while (results_seen < exp_q.size()) begin
         @(posedge clk_i);
         #1;
      end
   endtask

   task automatic set_mode(input logic xlate, input logic user, input logic sum);
      drain();
      trans_i = '{translation_en: xlate, priv_user: user, mstatus_sum: sum};
   endtask

   task automatic fill(input mem_addr_pkg::vtag_t vt, input mem_addr_pkg::ptag_t pt,
                       input logic u, input logic w, input logic d);
      drain();
      fill_i = '{vtag: vt, entry: '{ptag: pt, u: u, w: w, d: d}};
      fill_v_i = 1'b1;
      m_valid[m_ptr] = 1'b1;
      m_vtag[m_ptr] = vt;
      m_entry[m_ptr] = fill_i.entry;
      m_ptr = (m_ptr + 1) % tlb_els_lp;
      @(posedge clk_i);
      #1;
      fill_v_i = 1'b0;
   endtask

   task automatic flush_tlb();
      drain();
      sfence_i = 1'b1;
      for (int k = 0; k < tlb_els_lp; k++) begin
         m_valid[k] = 1'b0;
      end
      @(posedge clk_i);
      #1;
      sfence_i = 1'b0;
   endtask

   // Outputs are stable at the falling edge
   always @(negedge clk_i) begin
      if (reset_i) begin
         req_hist = 2'b00;
      end else begin
         assert (result_v_o == req_hist[1])
            else report_mismatch("result_v_o", 64'(req_hist[1]), 64'(result_v_o));
         if (result_v_o) begin
            assert (results_seen < exp_q.size())
               else report_failure("result_v_o rose with no request in flight");
            exp_r = exp_q[results_seen];
            assert (result_o.fault == exp_r.fault)
               else report_mismatch("result_o.fault", 64'(exp_r.fault), 64'(result_o.fault));
            assert (result_o.vaddr == exp_r.vaddr)
               else report_mismatch("result_o.vaddr", 64'(exp_r.vaddr), 64'(result_o.vaddr));
            assert (result_o.data == exp_r.data)
               else report_mismatch("result_o.data", exp_r.data, result_o.data);
            results_seen++;
         end
         req_hist = {req_hist[0], req_v_i};
      end
   end

   always @(posedge clk_i) begin
      cycle_count++;
      if (cycle_count > timeout_cycles_lp) begin
         $display("Timeout after %0d cycles with results still pending", cycle_count);
         $display("Verification failed");
         $fatal(1);
      end
   end

   initial begin
      lcg_state = 32'd53;
      reset_i = 1'b1;
      req_v_i = 1'b0;
      req_i = '0;
      trans_i = '0;
      fill_v_i = 1'b0;
      fill_i = '0;
      sfence_i = 1'b0;
      m_ptr = 0;
      for (int k = 0; k < tlb_els_lp; k++) begin
         m_valid[k] = 1'b0;
      end
      repeat (reset_cycles_lp) @(posedge clk_i);
      #1;
      reset_i = 1'b0;

      // Translation off, fill memory then mixed traffic
      for (int i = 0; i < dmem_words_lp; i++) begin
         send(mem_op_pkg::e_sd, 64'(i * 8), rand64());
      end
      send(mem_op_pkg::e_sd, 64'h48, 64'h8899_aabb_ccdd_eeff);
      for (int i = 0; i < 7; i++) begin
         send(mem_op_pkg::mem_op_e'(4'(i)), 64'h48, 64'h0);
      end
      repeat (rand_off_lp) rand_access(27'h0);

      // Misaligned accesses leave memory alone
      send(mem_op_pkg::e_sh, 64'h11, rand64());
      send(mem_op_pkg::e_sw, 64'h22, rand64());
      send(mem_op_pkg::e_sd, 64'h34, rand64());
      send(mem_op_pkg::e_lh, 64'h13, 64'h0);
      send(mem_op_pkg::e_lwu, 64'h1e, 64'h0);
      send(mem_op_pkg::e_ld, 64'h44, 64'h0);
      send(mem_op_pkg::e_ld, 64'h10, 64'h0);
      send(mem_op_pkg::e_ld, 64'h20, 64'h0);
      send(mem_op_pkg::e_ld, 64'h30, 64'h0);

      // Beyond the physical range
      send(mem_op_pkg::e_ld, 64'h200, 64'h0);
      send(mem_op_pkg::e_sw, 64'h1000, rand64());
      send(mem_op_pkg::e_lbu, 64'h7ff, 64'h0);

      // Translation on, supervisor mode
      set_mode(1'b1, 1'b0, 1'b0);
      send(mem_op_pkg::e_ld, page_addr(27'h10, 12'h40), 64'h0);
      fill(27'h10, 16'h0, 1'b0, 1'b1, 1'b1);
      send(mem_op_pkg::e_sd, page_addr(27'h10, 12'h40), rand64());
      send(mem_op_pkg::e_ld, page_addr(27'h10, 12'h40), 64'h0);
      repeat (16) rand_access(27'h10);
      flush_tlb();
      send(mem_op_pkg::e_ld, page_addr(27'h10, 12'h40), 64'h0);

      // The fifth fill lands on entry zero
      fill(27'h11, 16'h0, 1'b1, 1'b1, 1'b1);
      fill(27'h12, 16'h0, 1'b0, 1'b0, 1'b1);
      fill(27'h13, 16'h0, 1'b0, 1'b1, 1'b0);
      fill(27'h14, 16'h1, 1'b0, 1'b1, 1'b1);
      send(mem_op_pkg::e_lw, page_addr(27'h11, 12'h80), 64'h0);
      send(mem_op_pkg::e_sb, page_addr(27'h12, 12'h81), rand64());
      send(mem_op_pkg::e_sh, page_addr(27'h13, 12'h82), rand64());
      send(mem_op_pkg::e_lhu, page_addr(27'h12, 12'h82), 64'h0);
      send(mem_op_pkg::e_ld, page_addr(27'h14, 12'h0), 64'h0);
      send(mem_op_pkg::e_ld, page_addr(27'h10, 12'h40), 64'h0);
      send(mem_op_pkg::e_ld, 64'h0000_8000_0001_1000, 64'h0);
      send(mem_op_pkg::e_ld, 64'hffff_ffc0_0001_1000, 64'h0);

      set_mode(1'b1, 1'b0, 1'b1);
      send(mem_op_pkg::e_lw, page_addr(27'h11, 12'h80), 64'h0);
      send(mem_op_pkg::e_sw, page_addr(27'h11, 12'h84), rand64());
      set_mode(1'b1, 1'b1, 1'b0);
      send(mem_op_pkg::e_ld, page_addr(27'h11, 12'h80), 64'h0);
      send(mem_op_pkg::e_lb, page_addr(27'h12, 12'h10), 64'h0);

      for (int m = 0; m < 3; m++) begin
         set_mode(1'b1, m == 2, m == 1);
         repeat (rand_on_lp) rand_access(27'(27'h10 + rnd(6)));
      end

      // Sixth fill evicts the u page in entry one
      set_mode(1'b1, 1'b0, 1'b0);
      fill(27'h10, 16'h0, 1'b0, 1'b1, 1'b1);
      send(mem_op_pkg::e_ld, page_addr(27'h11, 12'h80), 64'h0);
      send(mem_op_pkg::e_ld, page_addr(27'h10, 12'h40), 64'h0);

      drain();
      repeat (4) @(posedge clk_i);
      if (results_seen == exp_q.size()) begin
         $display("Verification passed");
         $finish;
      end else begin
         $display("Error: %0d results for %0d requests", results_seen, exp_q.size());
         $display("Verification failed");
         $fatal(1);
      end
   end

endmodule
